//--- Makefile
# Verilator build and run of the rasterizer testbench.

LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench, fail if the log reports failure"
	@echo "make clean  remove build output and the log"
	@echo "make help   list these targets"

test:
	verilator --binary --timing -Wno-fatal --top-module rast_tb -f sim.f -o rast_sim
	./obj_dir/rast_sim | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- rtl/command_sequencer.sv
`timescale 1ns/100ps
/* Fetches and decodes the command list, owns the memory port and runs the
   producer handshake and the front-buffer swap. */
module command_sequencer import rast_pkg::*; (
    input  logic      clock,
    input  logic      reset_n,
    input  logic      data_ready,
    output logic      busy,
    output addr_t     address,
    output logic      read,
    output logic      write,
    output data_t     writedata,
    input  logic      waitrequest,
    input  data_t     readdata,
    input  logic      readdatavalid,
    input  logic      fb_front_buffer,
    output logic      rast_front_buffer,
    pixel_write_if.target wr,
    output logic      setup_start,
    output triangle_t tri_out,
    output logic      fill_start,
    output span_job_t fill_job,
    input  logic      span_done
);

    seq_state_t  state;
    addr_t       pc;
    addr_t       rd_addr;
    data_t       cmd_word;
    logic [15:0] tri_count;
    logic [1:0]  vert_idx;
    logic        drawing;

    // The span writer owns the bus while a fill or triangle is running.
    assign drawing = (state == st_clear_wait) || (state == st_draw_wait);
    assign wr.accept = wr.valid && !waitrequest && drawing;
    assign write = wr.valid && drawing;
    assign address = drawing ? wr.address : rd_addr;
    assign writedata = wr.data;

    always_comb begin
        fill_job = '0;
        fill_job.x_max = 10'(fb_width_px - 2);
        fill_job.y_max = 9'(fb_height_px - 1);
        fill_job.start_addr = back_base(rast_front_buffer);
        fill_job.color = word_color(cmd_word);
        fill_job.edge_test = 1'b0;
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= st_idle;
            busy <= 1'b0;
            read <= 1'b0;
            pc <= '0;
            tri_count <= '0;
            vert_idx <= '0;
            setup_start <= 1'b0;
            fill_start <= 1'b0;
            rast_front_buffer <= 1'b0;
        end else begin
            setup_start <= 1'b0;
            fill_start <= 1'b0;
            if (read && !waitrequest) begin
                read <= 1'b0;
            end
            case (state)
                st_idle: begin
                    state <= st_wait_data;
                end
                st_wait_data: begin
                    if (data_ready) begin
                        busy <= 1'b1;
                        state <= st_wait_no_data;
                    end
                end
                st_wait_no_data: begin
                    if (!data_ready) begin
                        pc <= prot_base_word;
                        state <= st_fetch;
                    end
                end
                st_fetch: begin
                    read <= 1'b1;
                    pc <= pc + 1'b1;
                    state <= st_fetch_wait;
                end
                st_fetch_wait: begin
                    if (readdatavalid) begin
                        state <= st_decode;
                    end
                end
                st_decode: begin
                    case (cmd_word[7:0])
                        op_clear: begin
                            fill_start <= 1'b1;
                            state <= st_clear_wait;
                        end
                        op_draw: begin
                            tri_count <= cmd_count(cmd_word);
                            state <= st_tri_next;
                        end
                        op_swap: begin
                            rast_front_buffer <= !rast_front_buffer;
                            state <= st_swap_wait;
                        end
                        default: begin
                            // END, or an unknown opcode, which aborts the list.
                            busy <= 1'b0;
                            state <= st_idle;
                        end
                    endcase
                end
                st_clear_wait: begin
                    if (span_done) begin
                        state <= st_fetch;
                    end
                end
                st_tri_next: begin
                    if (tri_count == '0) begin
                        state <= st_fetch;
                    end else begin
                        tri_count <= tri_count - 1'b1;
                        vert_idx <= '0;
                        state <= st_vert_read;
                    end
                end
                st_vert_read: begin
                    read <= 1'b1;
                    pc <= pc + 1'b1;
                    state <= st_vert_wait;
                end
                st_vert_wait: begin
                    if (readdatavalid) begin
                        if (vert_idx == 2'd2) begin
                            state <= st_setup;
                        end else begin
                            vert_idx <= vert_idx + 1'b1;
                            state <= st_vert_read;
                        end
                    end
                end
                st_setup: begin
                    setup_start <= 1'b1;
                    state <= st_draw_wait;
                end
                st_draw_wait: begin
                    if (span_done) begin
                        state <= st_tri_next;
                    end
                end
                st_swap_wait: begin
                    // No fetch until the display has taken the new front buffer.
                    if (fb_front_buffer == rast_front_buffer) begin
                        state <= st_fetch;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == st_fetch || state == st_vert_read) begin
            rd_addr <= pc;
        end
        if (readdatavalid && state == st_fetch_wait) begin
            cmd_word <= readdata;
        end
        if (readdatavalid && state == st_vert_wait) begin
            case (vert_idx)
                2'd0: tri_out.v0 <= readdata;
                2'd1: tri_out.v1 <= readdata;
                default: tri_out.v2 <= readdata;
            endcase
        end
    end

endmodule

//--- rtl/pixel_write_if.sv
`timescale 1ns/100ps
/* Pixel-word write requests from the span writer to the command sequencer,
   which forwards them to the memory bus. */
interface pixel_write_if import rast_pkg::*; ();

    addr_t address;
    data_t data;
    logic  valid;
    logic  accept;

    modport initiator (
        output address,
        output data,
        output valid,
        input  accept
    );

    modport target (
        input  address,
        input  data,
        input  valid,
        output accept
    );

endinterface

//--- rtl/rast_pkg.sv
/* Frame-buffer geometry, memory map, command encodings and job types shared by the
   rasterizer units and the testbench. Import with rast_pkg::*. */
package rast_pkg;

    localparam int fb_width_px = 32;
    localparam int fb_height_px = 16;
    localparam int fb_row_words = fb_width_px / 2;
    localparam int fb_words = fb_row_words * fb_height_px;

    typedef logic [28:0] addr_t;
    typedef logic [63:0] data_t;

    localparam addr_t fb_base_word = 29'h0000_1000;
    localparam addr_t prot_base_word = 29'h0000_0100;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } color_t;

    typedef enum logic [7:0] {
        op_clear = 8'd1,
        op_draw  = 8'd4,
        op_swap  = 8'd6,
        op_end   = 8'd7
    } opcode_t;

    typedef enum logic [3:0] {
        st_idle,
        st_wait_data,
        st_wait_no_data,
        st_fetch,
        st_fetch_wait,
        st_decode,
        st_clear_wait,
        st_tri_next,
        st_vert_read,
        st_vert_wait,
        st_setup,
        st_draw_wait,
        st_swap_wait
    } seq_state_t;

    typedef struct packed {
        data_t v0;
        data_t v1;
        data_t v2;
    } triangle_t;

    typedef struct packed {
        logic [9:0]         x_min;
        logic [9:0]         x_max;
        logic [8:0]         y_min;
        logic [8:0]         y_max;
        addr_t              start_addr;
        logic signed [21:0] w0;
        logic signed [21:0] w1;
        logic signed [21:0] w2;
        logic signed [10:0] step_x0;
        logic signed [10:0] step_x1;
        logic signed [10:0] step_x2;
        logic signed [10:0] step_y0;
        logic signed [10:0] step_y1;
        logic signed [10:0] step_y2;
        color_t             color;
        logic               edge_test;
    } span_job_t;

    // Vertex and command word fields.
    function automatic logic [9:0] vert_x(input data_t w);
        return w[11:2];
    endfunction

    function automatic logic [8:0] vert_y(input data_t w);
        return w[23:15];
    endfunction

    function automatic color_t word_color(input data_t w);
        return color_t'(w[63:40]);
    endfunction

    function automatic logic [15:0] cmd_count(input data_t w);
        return w[31:16];
    endfunction

    // Two pixels per word, each as 0,b,g,r.
    function automatic data_t color_word(input color_t c);
        return {8'h00, c.blue, c.green, c.red, 8'h00, c.blue, c.green, c.red};
    endfunction

    // Drawing always targets the buffer that is not on display.
    function automatic addr_t back_base(input logic front);
        return front ? fb_base_word : fb_base_word + addr_t'(fb_words);
    endfunction

endpackage

//--- rtl/rasterizer.sv
`timescale 1ns/100ps
/* Top level of the command-driven triangle rasterizer. Connects the sequencer,
   triangle setup and span writer to the producer, memory and display ports. */
module rasterizer import rast_pkg::*; (
    input  logic  clock,
    input  logic  reset_n,
    input  logic  data_ready,
    output logic  busy,
    output addr_t address,
    output logic  read,
    output logic  write,
    output data_t writedata,
    input  logic  waitrequest,
    input  data_t readdata,
    input  logic  readdatavalid,
    input  logic  fb_front_buffer,
    output logic  rast_front_buffer
);

    logic      setup_start;
    triangle_t tri_data;
    logic      fill_start;
    span_job_t fill_job;
    logic      job_valid;
    span_job_t job;
    logic      span_done;

    pixel_write_if wr_if ();

    command_sequencer command_sequencer_i (
        .clock             (clock),
        .reset_n           (reset_n),
        .data_ready        (data_ready),
        .busy              (busy),
        .address           (address),
        .read              (read),
        .write             (write),
        .writedata         (writedata),
        .waitrequest       (waitrequest),
        .readdata          (readdata),
        .readdatavalid     (readdatavalid),
        .fb_front_buffer   (fb_front_buffer),
        .rast_front_buffer (rast_front_buffer),
        .wr                (wr_if.target),
        .setup_start       (setup_start),
        .tri_out           (tri_data),
        .fill_start        (fill_start),
        .fill_job          (fill_job),
        .span_done         (span_done)
    );

    triangle_setup triangle_setup_i (
        .clock             (clock),
        .reset_n           (reset_n),
        .setup_start       (setup_start),
        .tri_in            (tri_data),
        .rast_front_buffer (rast_front_buffer),
        .job_valid         (job_valid),
        .job               (job)
    );

    span_writer span_writer_i (
        .clock      (clock),
        .reset_n    (reset_n),
        .job_valid  (job_valid),
        .job        (job),
        .fill_start (fill_start),
        .fill_job   (fill_job),
        .wr         (wr_if.initiator),
        .span_done  (span_done)
    );

endmodule

//--- rtl/span_writer.sv
`timescale 1ns/100ps
/* Walks a rectangle two pixels per word, for a clear fill or a triangle's box,
   and issues a write for every word that passes the edge test. */
module span_writer import rast_pkg::*; (
    input  logic      clock,
    input  logic      reset_n,
    input  logic      job_valid,
    input  span_job_t job,
    input  logic      fill_start,
    input  span_job_t fill_job,
    pixel_write_if.initiator wr,
    output logic      span_done
);

    span_job_t          src;
    span_job_t          cur;
    logic               active;
    logic               load;
    logic               advance;
    logic               row_end;
    logic               last;
    logic [9:0]         x;
    logic [8:0]         y;
    addr_t              row_addr;
    // Values for the next word and the next row, stepped one ahead.
    logic signed [21:0] w0;
    logic signed [21:0] w1;
    logic signed [21:0] w2;
    logic signed [21:0] w0_row;
    logic signed [21:0] w1_row;
    logic signed [21:0] w2_row;

    function automatic logic covered(input logic signed [21:0] a, b, c);
        return (a <= 0 && b <= 0 && c <= 0) || (a >= 0 && b >= 0 && c >= 0);
    endfunction

    assign src = fill_start ? fill_job : job;
    assign load = job_valid || fill_start;
    assign advance = active && (!wr.valid || wr.accept);
    assign row_end = (x == cur.x_max);
    assign last = row_end && (y == cur.y_max);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            active <= 1'b0;
            wr.valid <= 1'b0;
            span_done <= 1'b0;
        end else begin
            span_done <= 1'b0;
            if (load) begin
                active <= 1'b1;
                wr.valid <= !src.edge_test || covered(src.w0, src.w1, src.w2);
            end else if (advance) begin
                if (last) begin
                    active <= 1'b0;
                    wr.valid <= 1'b0;
                    span_done <= 1'b1;
                end else if (row_end) begin
                    wr.valid <= !cur.edge_test || covered(w0_row, w1_row, w2_row);
                end else begin
                    wr.valid <= !cur.edge_test || covered(w0, w1, w2);
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            cur <= src;
            x <= src.x_min;
            y <= src.y_min;
            wr.address <= src.start_addr;
            wr.data <= color_word(src.color);
            row_addr <= src.start_addr + addr_t'(fb_row_words);
            w0 <= src.w0 + src.step_x0;
            w1 <= src.w1 + src.step_x1;
            w2 <= src.w2 + src.step_x2;
            w0_row <= src.w0 + src.step_y0;
            w1_row <= src.w1 + src.step_y1;
            w2_row <= src.w2 + src.step_y2;
        end else if (advance && !last) begin
            if (row_end) begin
                x <= cur.x_min;
                y <= y + 9'd1;
                wr.address <= row_addr;
                row_addr <= row_addr + addr_t'(fb_row_words);
                w0 <= w0_row + cur.step_x0;
                w1 <= w1_row + cur.step_x1;
                w2 <= w2_row + cur.step_x2;
                w0_row <= w0_row + cur.step_y0;
                w1_row <= w1_row + cur.step_y1;
                w2_row <= w2_row + cur.step_y2;
            end else begin
                x <= x + 10'd2;
                wr.address <= wr.address + 1'b1;
                w0 <= w0 + cur.step_x0;
                w1 <= w1 + cur.step_x1;
                w2 <= w2 + cur.step_x2;
            end
        end
    end

endmodule

//--- rtl/triangle_setup.sv
`timescale 1ns/100ps
/* Two-cycle triangle setup. Turns three vertex words into a span job with the
   even-rounded bounding box, edge increments and edge values at the box corner. */
module triangle_setup import rast_pkg::*; (
    input  logic      clock,
    input  logic      reset_n,
    input  logic      setup_start,
    input  triangle_t tri_in,
    input  logic      rast_front_buffer,
    output logic      job_valid,
    output span_job_t job
);

    logic signed [10:0] sx_in [3];
    logic signed [10:0] sy_in [3];
    logic signed [10:0] vx [3];
    logic signed [10:0] vy [3];
    logic signed [10:0] step_x [3];
    logic signed [10:0] step_y [3];
    logic [9:0]         x_min;
    logic [9:0]         x_max;
    logic [8:0]         y_min;
    logic [8:0]         y_max;
    logic signed [10:0] corner_x;
    logic signed [10:0] corner_y;
    color_t             color;
    logic               box_valid;

    function automatic logic signed [10:0] min3(input logic signed [10:0] a, b, c);
        logic signed [10:0] m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic logic signed [10:0] max3(input logic signed [10:0] a, b, c);
        logic signed [10:0] m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    // Edge from (xb,yb) to (xc,yc), evaluated at (px,py).
    function automatic logic signed [21:0] edge_value(
        input logic signed [10:0] xb, yb, xc, yc, px, py);
        return (xc - xb) * (py - yb) - (yc - yb) * (px - xb);
    endfunction

    assign sx_in[0] = signed'({1'b0, vert_x(tri_in.v0)});
    assign sx_in[1] = signed'({1'b0, vert_x(tri_in.v1)});
    assign sx_in[2] = signed'({1'b0, vert_x(tri_in.v2)});
    assign sy_in[0] = signed'({2'b00, vert_y(tri_in.v0)});
    assign sy_in[1] = signed'({2'b00, vert_y(tri_in.v1)});
    assign sy_in[2] = signed'({2'b00, vert_y(tri_in.v2)});
    assign corner_x = signed'({1'b0, x_min});
    assign corner_y = signed'({2'b00, y_min});

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            box_valid <= 1'b0;
            job_valid <= 1'b0;
        end else begin
            box_valid <= setup_start;
            job_valid <= box_valid;
        end
    end

    // Bounding box and increments. Edge i runs from vertex i+1 to vertex i+2.
    always_ff @(posedge clock) begin
        if (setup_start) begin
            x_min <= 10'(min3(sx_in[0], sx_in[1], sx_in[2])) & ~10'd1;
            x_max <= 10'(max3(sx_in[0], sx_in[1], sx_in[2])) & ~10'd1;
            y_min <= 9'(min3(sy_in[0], sy_in[1], sy_in[2])) & ~9'd1;
            y_max <= 9'(max3(sy_in[0], sy_in[1], sy_in[2])) & ~9'd1;
            for (int i = 0; i < 3; i++) begin
                vx[i] <= sx_in[i];
                vy[i] <= sy_in[i];
                step_x[i] <= (sy_in[(i + 1) % 3] - sy_in[(i + 2) % 3]) <<< 1;
                step_y[i] <= sx_in[(i + 2) % 3] - sx_in[(i + 1) % 3];
            end
            color <= word_color(tri_in.v0);
        end
    end

    always_ff @(posedge clock) begin
        if (box_valid) begin
            job.x_min <= x_min;
            job.x_max <= x_max;
            job.y_min <= y_min;
            job.y_max <= y_max;
            job.start_addr <= back_base(rast_front_buffer)
                + addr_t'((y_min * fb_width_px + x_min) >> 1);
            job.w0 <= edge_value(vx[1], vy[1], vx[2], vy[2], corner_x, corner_y);
            job.w1 <= edge_value(vx[2], vy[2], vx[0], vy[0], corner_x, corner_y);
            job.w2 <= edge_value(vx[0], vy[0], vx[1], vy[1], corner_x, corner_y);
            job.step_x0 <= step_x[0];
            job.step_x1 <= step_x[1];
            job.step_x2 <= step_x[2];
            job.step_y0 <= step_y[0];
            job.step_y1 <= step_y[1];
            job.step_y2 <= step_y[2];
            job.color <= color;
            job.edge_test <= 1'b1;
        end
    end

endmodule

//--- sim.f
rtl/rast_pkg.sv
rtl/pixel_write_if.sv
rtl/command_sequencer.sv
rtl/triangle_setup.sv
rtl/span_writer.sv
rtl/rasterizer.sv
tb/rast_checker.sv
tb/rast_tb.sv

//--- tb/rast_checker.sv
`timescale 1ns/100ps
/* Testbench checker. Shadows both frame buffers from observed bus writes, keeps a
   reference image built from the command lists, compares them per test and times out. */
module rast_checker import rast_pkg::*; (
    input logic  clock,
    input logic  reset_n,
    input logic  busy,
    input addr_t address,
    input logic  read,
    input logic  write,
    input data_t writedata,
    input logic  waitrequest,
    input logic  fb_front_buffer,
    input logic  rast_front_buffer
);

    data_t shadow [2 * fb_words];
    data_t ref_img [2 * fb_words];
    string test_name;
    int    errors;
    int    tests_run;
    int    tests_failed;
    int    cycles;
    int    cycle_limit;
    logic  timed_out;

    // Initial contents differ at every address.
    function automatic data_t fill_word(input int i);
        return {~32'(i), 32'(i) ^ 32'h5a5a_0000};
    endfunction

    function automatic data_t pixel_pair(input data_t v);
        return {8'h00, v[47:40], v[55:48], v[63:56], 8'h00, v[47:40], v[55:48], v[63:56]};
    endfunction

    function automatic int edge_at(input int xb, yb, xc, yc, x, y);
        return (xc - xb) * (y - yb) - (yc - yb) * (x - xb);
    endfunction

    initial begin
        for (int i = 0; i < 2 * fb_words; i++) begin
            shadow[i] = fill_word(i);
            ref_img[i] = fill_word(i);
        end
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        cycles = 0;
        cycle_limit = 0;
        timed_out = 1'b0;
    end

    task automatic start_test(input string name, input int est_words);
        test_name = name;
        cycles = 0;
        cycle_limit = 2 * est_words;
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic add_clear(input int buf_sel, input data_t cmd);
        for (int i = 0; i < fb_words; i++) begin
            ref_img[buf_sel * fb_words + i] = pixel_pair(cmd);
        end
    endtask

    // Flat colour of vertex 0 on every even pixel pair inside all three edges.
    task automatic add_triangle(input int buf_sel, input data_t v0, v1, v2);
        int xs [3];
        int ys [3];
        int x_lo;
        int x_hi;
        int y_lo;
        int y_hi;
        int e0;
        int e1;
        int e2;
        xs[0] = int'(v0[11:2]);
        xs[1] = int'(v1[11:2]);
        xs[2] = int'(v2[11:2]);
        ys[0] = int'(v0[23:15]);
        ys[1] = int'(v1[23:15]);
        ys[2] = int'(v2[23:15]);
        x_lo = xs[0];
        x_hi = xs[0];
        y_lo = ys[0];
        y_hi = ys[0];
        for (int i = 1; i < 3; i++) begin
            x_lo = (xs[i] < x_lo) ? xs[i] : x_lo;
            x_hi = (xs[i] > x_hi) ? xs[i] : x_hi;
            y_lo = (ys[i] < y_lo) ? ys[i] : y_lo;
            y_hi = (ys[i] > y_hi) ? ys[i] : y_hi;
        end
        x_lo = x_lo & ~1;
        x_hi = x_hi & ~1;
        y_lo = y_lo & ~1;
        y_hi = y_hi & ~1;
        for (int y = y_lo; y <= y_hi; y++) begin
            for (int x = x_lo; x <= x_hi; x += 2) begin
                e0 = edge_at(xs[1], ys[1], xs[2], ys[2], x, y);
                e1 = edge_at(xs[2], ys[2], xs[0], ys[0], x, y);
                e2 = edge_at(xs[0], ys[0], xs[1], ys[1], x, y);
                if ((e0 >= 0 && e1 >= 0 && e2 >= 0) || (e0 <= 0 && e1 <= 0 && e2 <= 0)) begin
                    ref_img[buf_sel * fb_words + (y * fb_width_px + x) / 2] = pixel_pair(v0);
                end
            end
        end
    endtask

    task automatic check_test();
        int shown;
        shown = 0;
        for (int i = 0; i < 2 * fb_words; i++) begin
            if (shadow[i] !== ref_img[i]) begin
                if (shown < 4) begin
                    $display("ERR writedata addr %h got %h expected %h",
                             fb_base_word + addr_t'(i), shadow[i], ref_img[i]);
                end
                shown++;
                errors++;
            end
        end
        tests_run++;
        if (errors == 0) begin
            $display("test %s: pass", test_name);
        end else begin
            tests_failed++;
            $display("test %s: fail, %0d errors", test_name, errors);
        end
        errors = 0;
        cycle_limit = 0;
    endtask

    task automatic report();
        $display("tests run %0d, failed %0d", tests_run, tests_failed);
    endtask

    always @(posedge clock) begin
        if (reset_n) begin
            if (write && !waitrequest) begin
                if (address >= fb_base_word && address < fb_base_word + addr_t'(2 * fb_words)) begin
                    shadow[address - fb_base_word] = writedata;
                end else begin
                    $display("Write outside the frame buffers at address %h", address);
                    errors++;
                end
            end
            if (write && !busy) begin
                $display("Write at address %h while the DUT is not busy", address);
                errors++;
            end
            if (read && fb_front_buffer != rast_front_buffer) begin
                $display("Read issued before the display took the new front buffer");
                errors++;
            end
            cycles++;
            if (cycle_limit > 0 && cycles > cycle_limit && !timed_out) begin
                $display("Timeout: test %s did not finish within %0d cycles",
                         test_name, cycle_limit);
                timed_out = 1'b1;
            end
        end
    end

endmodule

//--- tb/rast_tb.sv
`timescale 1ns/100ps
/* Top-level testbench. Drives command lists through the rasterizer with a memory model
   that inserts random wait states and a display side that answers buffer swaps. */
module rast_tb import rast_pkg::*; ();

    logic  clock;
    logic  reset_n;
    logic  data_ready;
    logic  busy;
    addr_t address;
    logic  read;
    logic  write;
    data_t writedata;
    logic  waitrequest;
    data_t readdata;
    logic  readdatavalid;
    logic  fb_front_buffer;
    logic  rast_front_buffer;

    data_t  mem [8192];
    data_t  cmd_q [$];
    integer seed = 60;
    int     rd_wait;
    addr_t  rd_addr;
    int     swap_cnt;
    logic   front;
    data_t  tri_v [3];

    rasterizer rasterizer_i (.*);

    rast_checker checker_i (
        .clock             (clock),
        .reset_n           (reset_n),
        .busy              (busy),
        .address           (address),
        .read              (read),
        .write             (write),
        .writedata         (writedata),
        .waitrequest       (waitrequest),
        .fb_front_buffer   (fb_front_buffer),
        .rast_front_buffer (rast_front_buffer)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Memory side bookkeeping on the edge where the DUT samples the bus.
    always @(posedge clock) begin
        if (read && !waitrequest) begin
            rd_addr = address;
            rd_wait = 1 + ($unsigned($random(seed)) % 3);
        end
        if (write && !waitrequest) begin
            mem[address[12:0]] = writedata;
        end
    end

    always @(negedge clock) begin
        waitrequest = (($random(seed) & 3) == 0);
        readdatavalid = 1'b0;
        readdata = '0;
        if (rd_wait > 0) begin
            rd_wait--;
            if (rd_wait == 0) begin
                readdatavalid = 1'b1;
                readdata = mem[rd_addr[12:0]];
            end
        end
        // Display side follows the new front buffer after a random delay.
        if (fb_front_buffer != rast_front_buffer) begin
            if (swap_cnt < 0) begin
                swap_cnt = 2 + ($random(seed) & 7);
            end else if (swap_cnt == 0) begin
                fb_front_buffer = rast_front_buffer;
                swap_cnt = -1;
            end else begin
                swap_cnt--;
            end
        end
    end

    function automatic data_t make_cmd(input logic [7:0] op, input int count, input color_t c);
        data_t w;
        w = '0;
        w[7:0] = op;
        w[31:16] = 16'(count);
        w[63:40] = c;
        return w;
    endfunction

    task automatic random_triangle();
        color_t c;
        c = color_t'($random(seed));
        for (int i = 0; i < 3; i++) begin
            tri_v[i] = '0;
            tri_v[i][63:40] = c;
            tri_v[i][11:2] = 10'($unsigned($random(seed)) % fb_width_px);
            tri_v[i][23:15] = 9'($unsigned($random(seed)) % fb_height_px);
        end
    endtask

    // Loads the list, runs the producer handshake and waits for busy to fall.
    task automatic run_list(input string name, input int est_words);
        for (int i = 0; i < cmd_q.size(); i++) begin
            mem[prot_base_word[12:0] + 13'(i)] = cmd_q[i];
        end
        checker_i.start_test(name, est_words + 8 * cmd_q.size() + 40);
        @(negedge clock);
        checker_i.check_bit("busy", busy, 1'b0);
        data_ready = 1'b1;
        @(negedge clock);
        checker_i.check_bit("busy", busy, 1'b1);
        data_ready = 1'b0;
        while (busy) begin
            @(negedge clock);
        end
        repeat (20) @(negedge clock);
        checker_i.check_bit("rast_front_buffer", rast_front_buffer, front);
        checker_i.check_test();
        cmd_q.delete();
    endtask

    initial begin
        wait (checker_i.timed_out);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        reset_n = 1'b0;
        data_ready = 1'b0;
        waitrequest = 1'b1;
        readdata = '0;
        readdatavalid = 1'b0;
        fb_front_buffer = 1'b0;
        rd_wait = 0;
        rd_addr = '0;
        swap_cnt = -1;
        front = 1'b0;
        for (int i = 0; i < 8192; i++) begin
            mem[i] = {~32'(i), 32'(i)};
        end
        repeat (8) @(negedge clock);
        reset_n = 1'b1;

        checker_i.check_bit("busy", busy, 1'b0);
        checker_i.check_bit("read", read, 1'b0);
        checker_i.check_bit("write", write, 1'b0);
        checker_i.check_bit("rast_front_buffer", rast_front_buffer, 1'b0);
        cmd_q.push_back(make_cmd(op_end, 0, '0));
        run_list("reset_and_busy", 0);

        cmd_q.push_back(make_cmd(op_clear, 0, 24'h12_34_56));
        cmd_q.push_back(make_cmd(op_end, 0, '0));
        checker_i.add_clear(!front, cmd_q[0]);
        run_list("clear", fb_words);

        cmd_q.push_back(make_cmd(op_clear, 0, 24'h20_40_60));
        checker_i.add_clear(!front, cmd_q[0]);
        cmd_q.push_back(make_cmd(op_draw, 2, '0));
        for (int t = 0; t < 2; t++) begin
            random_triangle();
            for (int i = 0; i < 3; i++) begin
                cmd_q.push_back(tri_v[i]);
            end
            checker_i.add_triangle(!front, tri_v[0], tri_v[1], tri_v[2]);
        end
        cmd_q.push_back(make_cmd(op_end, 0, '0));
        run_list("draw_triangles", 3 * fb_words);

        cmd_q.push_back(make_cmd(op_swap, 0, '0));
        front = !front;
        cmd_q.push_back(make_cmd(op_clear, 0, 24'hab_cd_ef));
        checker_i.add_clear(!front, cmd_q[1]);
        cmd_q.push_back(make_cmd(op_end, 0, '0));
        run_list("swap_then_clear", fb_words + 20);

        // The clear after the unknown opcode must never run.
        cmd_q.push_back(make_cmd(op_clear, 0, 24'h0f_0f_0f));
        checker_i.add_clear(!front, cmd_q[0]);
        cmd_q.push_back(make_cmd(8'h09, 0, '0));
        cmd_q.push_back(make_cmd(op_clear, 0, 24'hf0_f0_f0));
        cmd_q.push_back(make_cmd(op_end, 0, '0));
        run_list("unknown_opcode", fb_words);

        checker_i.report();
        if (checker_i.tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
